// File: hw/dram_sim_pkg.sv
// DRAM simulation shared definitions
`default_nettype none

package dram_sim_pkg;

  // Bus widths
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 64;

  // One strobe bit per data byte
  localparam int unsigned STRB_W = DATA_W / 8;

  // AXI response encoding, only the two codes this model returns
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    DECERR = 2'b11
  } resp_e;

  // Read response as returned by the storage model
  typedef struct packed {
    logic [DATA_W-1:0] data;
    resp_e             resp;
  } rd_rsp_t;

endpackage : dram_sim_pkg

`default_nettype wire

// File: hw/dram_req_if.sv
// DRAM request stream interface
`timescale 1ns/1ps
`default_nettype none

interface dram_req_if #(
  parameter int unsigned IdxW = 6
);
  import dram_sim_pkg::*;

  logic              valid;
  logic              ready;
  logic              we;
  logic [IdxW-1:0]   idx;
  logic [DATA_W-1:0] wdata;
  logic [STRB_W-1:0] wstrb;

  modport producer (output valid, we, idx, wdata, wstrb, input ready);

  modport consumer (input valid, we, idx, wdata, wstrb, output ready);

  // Passive view of the whole stream
  modport arbiter (input valid, ready, we, idx, wdata, wstrb);

endinterface : dram_req_if

`default_nettype wire

// File: hw/lite_to_dram_req.sv
// AXI-Lite to DRAM request converter
`timescale 1ns/1ps
`default_nettype none

module lite_to_dram_req #(
  parameter logic [dram_sim_pkg::ADDR_W-1:0] BaseAddr   = 32'h8000_0000,
  parameter int unsigned                     MemWords   = 64,
  parameter int unsigned                     BFifoDepth = 4,
  parameter int unsigned                     RspDepth   = 4
) (
  input  logic                              clk_i,
  input  logic                              arst_n_i,
  input  logic                              aw_valid_i,
  output logic                              aw_ready_o,
  input  logic [dram_sim_pkg::ADDR_W-1:0]   aw_addr_i,
  input  logic                              w_valid_i,
  output logic                              w_ready_o,
  input  logic [dram_sim_pkg::DATA_W-1:0]   w_data_i,
  input  logic [dram_sim_pkg::STRB_W-1:0]   w_strb_i,
  output logic                              b_valid_o,
  input  logic                              b_ready_i,
  output logic [1:0]                        b_resp_o,
  input  logic                              ar_valid_i,
  output logic                              ar_ready_o,
  input  logic [dram_sim_pkg::ADDR_W-1:0]   ar_addr_i,
  output logic                              r_valid_o,
  input  logic                              r_ready_i,
  output logic [dram_sim_pkg::DATA_W-1:0]   r_data_o,
  output logic [1:0]                        r_resp_o,
  dram_req_if.producer                      rd_req,
  dram_req_if.producer                      wr_req,
  input  logic                              rd_rsp_valid_i,
  input  dram_sim_pkg::rd_rsp_t             rd_rsp_i,
  output logic                              rd_rsp_ready_o
);
  import dram_sim_pkg::*;

  localparam int unsigned OffW     = $clog2(STRB_W);
  localparam int unsigned IdxW     = $clog2(MemWords);
  localparam int unsigned TagDepth = RspDepth + 2;
  localparam int unsigned BPtrW    = (BFifoDepth > 1) ? $clog2(BFifoDepth) : 1;
  localparam int unsigned TPtrW    = $clog2(TagDepth);

  // Word offset from the window base
  function automatic logic [ADDR_W-1:0] word_of(input logic [ADDR_W-1:0] addr);
    logic [ADDR_W-1:0] aligned;
    aligned = {addr[ADDR_W-1:OffW], {OffW{1'b0}}};
    return (aligned - BaseAddr) >> OffW;
  endfunction

  logic              live_q;
  logic [ADDR_W-1:0] aw_word, ar_word;
  logic              aw_in, ar_in;
  logic              wr_go, wr_accept, ar_go;

  resp_e                          b_mem [BFifoDepth];
  logic [BPtrW-1:0]               b_wptr, b_rptr;
  logic [$clog2(BFifoDepth+1)-1:0] b_cnt;
  logic                           b_full, b_push, b_pop;

  // Tag set means the read was out of range
  logic                          tag_mem [TagDepth];
  logic [TPtrW-1:0]              tag_wptr, tag_rptr;
  logic [$clog2(TagDepth+1)-1:0] tag_cnt;
  logic                          tag_full, tag_empty, tag_err, tag_push, tag_pop;

  // Keeps every ready low in the first cycle out of reset
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) live_q <= 1'b0;
    else           live_q <= 1'b1;
  end

  assign aw_word = word_of(aw_addr_i);
  assign ar_word = word_of(ar_addr_i);
  assign aw_in   = aw_word < MemWords;
  assign ar_in   = ar_word < MemWords;

  // Write joins AW and W, out of range skips the memory
  assign wr_go        = live_q & aw_valid_i & w_valid_i & ~b_full;
  assign wr_req.valid = wr_go & aw_in;
  assign wr_req.we    = 1'b1;
  assign wr_req.idx   = aw_word[IdxW-1:0];
  assign wr_req.wdata = w_data_i;
  assign wr_req.wstrb = w_strb_i;
  assign wr_accept    = wr_go & (~aw_in | wr_req.ready);
  assign aw_ready_o   = wr_accept;
  assign w_ready_o    = wr_accept;

  assign b_full    = b_cnt == BFifoDepth;
  assign b_push    = wr_accept;
  assign b_pop     = b_valid_o & b_ready_i;
  assign b_valid_o = b_cnt != 0;
  assign b_resp_o  = b_mem[b_rptr];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      b_wptr <= '0;
      b_rptr <= '0;
      b_cnt  <= '0;
    end else begin
      if (b_push) b_wptr <= (b_wptr == BPtrW'(BFifoDepth - 1)) ? '0 : b_wptr + 1'b1;
      if (b_pop)  b_rptr <= (b_rptr == BPtrW'(BFifoDepth - 1)) ? '0 : b_rptr + 1'b1;
      if (b_push && !b_pop)      b_cnt <= b_cnt + 1'b1;
      else if (!b_push && b_pop) b_cnt <= b_cnt - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (b_push) b_mem[b_wptr] <= aw_in ? OKAY : DECERR;
  end

  // Read requests, every AR leaves an order tag
  assign ar_go        = live_q & ar_valid_i & ~tag_full;
  assign rd_req.valid = ar_go & ar_in;
  assign rd_req.we    = 1'b0;
  assign rd_req.idx   = ar_word[IdxW-1:0];
  assign rd_req.wdata = '0;
  assign rd_req.wstrb = '0;
  assign ar_ready_o   = ar_go & (~ar_in | rd_req.ready);

  assign tag_full  = tag_cnt == TagDepth;
  assign tag_empty = tag_cnt == 0;
  assign tag_err   = tag_mem[tag_rptr];
  assign tag_push  = ar_valid_i & ar_ready_o;
  assign tag_pop   = r_valid_o & r_ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      tag_wptr <= '0;
      tag_rptr <= '0;
      tag_cnt  <= '0;
    end else begin
      if (tag_push) tag_wptr <= (tag_wptr == TPtrW'(TagDepth - 1)) ? '0 : tag_wptr + 1'b1;
      if (tag_pop)  tag_rptr <= (tag_rptr == TPtrW'(TagDepth - 1)) ? '0 : tag_rptr + 1'b1;
      tag_cnt <= tag_cnt + tag_push - tag_pop;
    end
  end

  always_ff @(posedge clk_i) begin
    if (tag_push) tag_mem[tag_wptr] <= ~ar_in;
  end

  // Head tag picks memory data or a local error beat
  assign r_valid_o      = ~tag_empty & (tag_err | rd_rsp_valid_i);
  assign r_data_o       = tag_err ? '0 : rd_rsp_i.data;
  assign r_resp_o       = tag_err ? DECERR : rd_rsp_i.resp;
  assign rd_rsp_ready_o = ~tag_empty & ~tag_err & r_ready_i;

endmodule : lite_to_dram_req

`default_nettype wire

// File: hw/rw_arbiter.sv
// Read/write round-robin arbiter
`timescale 1ns/1ps
`default_nettype none

module rw_arbiter (
  input  logic         clk_i,
  input  logic         arst_n_i,
  dram_req_if.consumer rd_req,
  dram_req_if.consumer wr_req,
  dram_req_if.producer mem_req
);

  // Selection, 1 means read
  logic sel;
  logic sel_q;
  logic prio_q;
  logic lock_q;
  logic fire;

  always_comb begin
    if (lock_q) begin
      sel = sel_q;
    end else if (rd_req.valid && wr_req.valid) begin
      sel = prio_q;
    end else begin
      sel = rd_req.valid;
    end
  end

  assign mem_req.valid = sel ? rd_req.valid : wr_req.valid;
  assign mem_req.we    = sel ? rd_req.we    : wr_req.we;
  assign mem_req.idx   = sel ? rd_req.idx   : wr_req.idx;
  assign mem_req.wdata = sel ? rd_req.wdata : wr_req.wdata;
  assign mem_req.wstrb = sel ? rd_req.wstrb : wr_req.wstrb;

  assign rd_req.ready = sel & mem_req.ready;
  assign wr_req.ready = ~sel & mem_req.ready;

  assign fire = mem_req.valid & mem_req.ready;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      lock_q <= 1'b0;
      sel_q  <= 1'b0;
      prio_q <= 1'b1;
    end else begin
      // Hold the grant until the stalled beat goes through
      lock_q <= mem_req.valid & ~mem_req.ready;
      sel_q  <= sel;
      if (fire) begin
        prio_q <= ~sel;
      end
    end
  end

endmodule : rw_arbiter

`default_nettype wire

// File: hw/dram_model.sv
// Fixed-latency DRAM storage model
`timescale 1ns/1ps
`default_nettype none

module dram_model #(
  parameter int unsigned MemWords = 64,
  parameter int unsigned Latency  = 4,
  parameter int unsigned RspDepth = 4
) (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  dram_req_if.consumer          mem_req,
  output logic                  rd_rsp_valid_o,
  output dram_sim_pkg::rd_rsp_t rd_rsp_o,
  input  logic                  rd_rsp_ready_i
);
  import dram_sim_pkg::*;

  localparam int unsigned QPtrW = (RspDepth > 1) ? $clog2(RspDepth) : 1;
  localparam int unsigned QCntW = $clog2(RspDepth + 1);
  localparam int unsigned FlyW  = $clog2(Latency + 1);

  logic [DATA_W-1:0] mem [MemWords];

  logic wr_fire;
  logic rd_fire;

  // Read pipeline, one item per stage
  logic [Latency-1:0] pipe_v;
  logic [DATA_W-1:0]  pipe_d [Latency];
  logic               pipe_out;
  logic [FlyW-1:0]    fly_cnt;

  // Response queue
  rd_rsp_t          q_mem [RspDepth];
  logic [QPtrW-1:0] q_wptr;
  logic [QPtrW-1:0] q_rptr;
  logic [QCntW-1:0] q_cnt;
  logic             q_push;
  logic             q_pop;

  assign wr_fire = mem_req.valid & mem_req.ready & mem_req.we;
  assign rd_fire = mem_req.valid & mem_req.ready & ~mem_req.we;

  // Back-pressure so every read in flight has a queue slot
  assign mem_req.ready = (int'(q_cnt) + int'(fly_cnt)) < int'(RspDepth);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int w = 0; w < MemWords; w++) begin
        mem[w] <= '0;
      end
    end else if (wr_fire) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (mem_req.wstrb[b]) begin
          mem[mem_req.idx][8*b +: 8] <= mem_req.wdata[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pipe_v  <= '0;
      fly_cnt <= '0;
    end else begin
      pipe_v <= {pipe_v[Latency-2:0], rd_fire};
      if (rd_fire && !pipe_out) begin
        fly_cnt <= fly_cnt + 1'b1;
      end else if (!rd_fire && pipe_out) begin
        fly_cnt <= fly_cnt - 1'b1;
      end
    end
  end

  // Data is sampled when the read is issued
  always_ff @(posedge clk_i) begin
    pipe_d[0] <= mem[mem_req.idx];
    for (int s = 1; s < Latency; s++) begin
      pipe_d[s] <= pipe_d[s-1];
    end
  end

  assign pipe_out = pipe_v[Latency-1];

  assign q_push         = pipe_out;
  assign q_pop          = rd_rsp_valid_o & rd_rsp_ready_i;
  assign rd_rsp_valid_o = q_cnt != 0;
  assign rd_rsp_o       = q_mem[q_rptr];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      q_wptr <= '0;
      q_rptr <= '0;
      q_cnt  <= '0;
    end else begin
      if (q_push) begin
        q_wptr <= (q_wptr == QPtrW'(RspDepth - 1)) ? '0 : q_wptr + 1'b1;
      end
      if (q_pop) begin
        q_rptr <= (q_rptr == QPtrW'(RspDepth - 1)) ? '0 : q_rptr + 1'b1;
      end
      if (q_push && !q_pop) begin
        q_cnt <= q_cnt + 1'b1;
      end else if (!q_push && q_pop) begin
        q_cnt <= q_cnt - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (q_push) begin
      q_mem[q_wptr] <= '{data: pipe_d[Latency-1], resp: OKAY};
    end
  end

endmodule : dram_model

`default_nettype wire

// File: hw/axi_lite_dram_sim.sv
// AXI-Lite DRAM simulation top
`timescale 1ns/1ps
`default_nettype none

module axi_lite_dram_sim #(
  parameter logic [dram_sim_pkg::ADDR_W-1:0] BaseAddr   = 32'h8000_0000,
  parameter int unsigned                     MemWords   = 64,
  parameter int unsigned                     Latency    = 4,
  parameter int unsigned                     BFifoDepth = 4,
  parameter int unsigned                     RspDepth   = 4
) (
  input  logic                            clk_i,
  input  logic                            arst_n_i,
  input  logic                            aw_valid_i,
  output logic                            aw_ready_o,
  input  logic [dram_sim_pkg::ADDR_W-1:0] aw_addr_i,
  input  logic                            w_valid_i,
  output logic                            w_ready_o,
  input  logic [dram_sim_pkg::DATA_W-1:0] w_data_i,
  input  logic [dram_sim_pkg::STRB_W-1:0] w_strb_i,
  output logic                            b_valid_o,
  input  logic                            b_ready_i,
  output logic [1:0]                      b_resp_o,
  input  logic                            ar_valid_i,
  output logic                            ar_ready_o,
  input  logic [dram_sim_pkg::ADDR_W-1:0] ar_addr_i,
  output logic                            r_valid_o,
  input  logic                            r_ready_i,
  output logic [dram_sim_pkg::DATA_W-1:0] r_data_o,
  output logic [1:0]                      r_resp_o
);
  import dram_sim_pkg::*;

  localparam int unsigned IdxW = $clog2(MemWords);

  dram_req_if #(.IdxW(IdxW)) rd_req_if ();
  dram_req_if #(.IdxW(IdxW)) wr_req_if ();
  dram_req_if #(.IdxW(IdxW)) mem_req_if ();

  logic    rd_rsp_valid;
  logic    rd_rsp_ready;
  rd_rsp_t rd_rsp;

  lite_to_dram_req #(
    .BaseAddr  (BaseAddr  ),
    .MemWords  (MemWords  ),
    .BFifoDepth(BFifoDepth),
    .RspDepth  (RspDepth  )
  ) u_lite_to_dram_req (
    .clk_i, .arst_n_i,
    .aw_valid_i, .aw_ready_o, .aw_addr_i,
    .w_valid_i, .w_ready_o, .w_data_i, .w_strb_i,
    .b_valid_o, .b_ready_i, .b_resp_o,
    .ar_valid_i, .ar_ready_o, .ar_addr_i,
    .r_valid_o, .r_ready_i, .r_data_o, .r_resp_o,
    .rd_req        (rd_req_if   ),
    .wr_req        (wr_req_if   ),
    .rd_rsp_valid_i(rd_rsp_valid),
    .rd_rsp_i      (rd_rsp      ),
    .rd_rsp_ready_o(rd_rsp_ready)
  );

  rw_arbiter u_rw_arbiter (
    .clk_i, .arst_n_i,
    .rd_req (rd_req_if ),
    .wr_req (wr_req_if ),
    .mem_req(mem_req_if)
  );

  dram_model #(
    .MemWords(MemWords),
    .Latency (Latency ),
    .RspDepth(RspDepth)
  ) u_dram_model (
    .clk_i, .arst_n_i,
    .mem_req       (mem_req_if  ),
    .rd_rsp_valid_o(rd_rsp_valid),
    .rd_rsp_o      (rd_rsp      ),
    .rd_rsp_ready_i(rd_rsp_ready)
  );

endmodule : axi_lite_dram_sim

`default_nettype wire

// File: verification/axi_lite_dram_sim_props.sv
// AXI-Lite DRAM protocol checks
`timescale 1ns/1ps
`default_nettype none

module axi_lite_dram_sim_props #(
  parameter logic [31:0] BaseAddr = 32'h8000_0000,
  parameter int unsigned MemWords = 64,
  parameter int unsigned Latency  = 4
) (
  input wire logic        clk_i,
  input wire logic        arst_n_i,
  input wire logic        b_valid_o,
  input wire logic        b_ready_i,
  input wire logic [1:0]  b_resp_o,
  input wire logic        r_valid_o,
  input wire logic        r_ready_i,
  input wire logic [63:0] r_data_o,
  input wire logic [1:0]  r_resp_o,
  input wire logic        ar_valid_i,
  input wire logic        ar_ready_o,
  input wire logic [31:0] ar_addr_i
);

  logic [7:0]  pending_q;
  logic        ar_fire;
  logic        r_fire;
  logic [31:0] ar_word;

  assign ar_fire = ar_valid_i & ar_ready_o;
  assign r_fire  = r_valid_o & r_ready_i;
  assign ar_word = ((ar_addr_i & ~32'h7) - BaseAddr) >> 3;

  // Reads accepted but not yet returned
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) pending_q <= '0;
    else           pending_q <= pending_q + ar_fire - r_fire;
  end

  b_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    b_valid_o && !b_ready_i |=> b_valid_o && $stable(b_resp_o))
    else $error("B channel changed while stalled");

  r_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_data_o) && $stable(r_resp_o))
    else $error("R channel changed while stalled");

  quiet_after_reset: assert property (@(posedge clk_i)
    $rose(arst_n_i) |-> !b_valid_o && !r_valid_o)
    else $error("Response valid right after reset");

  read_latency: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    ar_fire && ar_word < MemWords && pending_q == 0 |=> !r_valid_o [*Latency])
    else $error("Read data returned too early");

endmodule : axi_lite_dram_sim_props

bind axi_lite_dram_sim axi_lite_dram_sim_props #(
  .BaseAddr(BaseAddr),
  .MemWords(MemWords),
  .Latency (Latency )
) u_props (.*);

`default_nettype wire

// File: verification/tb_axi_lite_dram_sim.sv
// AXI-Lite DRAM simulation testbench
`timescale 1ns/1ps
`default_nettype none

module tb_axi_lite_dram_sim;

  localparam logic [31:0] BASE      = 32'h8000_0000;
  localparam int          WORDS     = 64;
  localparam int          NUM_OPS   = 344;
  localparam int          OP_CYCLES = 40;

  logic        clk_i = 1'b0;
  logic        arst_n_i = 1'b0;
  logic        aw_valid_i = 1'b0, w_valid_i = 1'b0, ar_valid_i = 1'b0;
  logic        b_ready_i = 1'b1, r_ready_i = 1'b1;
  logic [31:0] aw_addr_i = '0, ar_addr_i = '0;
  logic [63:0] w_data_i = '0;
  logic [7:0]  w_strb_i = '0;
  logic        aw_ready_o, w_ready_o, ar_ready_o, b_valid_o, r_valid_o;
  logic [1:0]  b_resp_o, r_resp_o;
  logic [63:0] r_data_o;

  logic [31:0] rng = 32'hfff6_2c1e;
  logic [63:0] shadow [WORDS];
  logic [63:0] exp_data [$];
  logic [1:0]  exp_rresp [$];
  logic [1:0]  exp_bresp [$];
  logic        stall_on = 1'b0;
  int          r_hold = 0, b_hold = 0;

  axi_lite_dram_sim #(.BaseAddr(BASE), .MemWords(WORDS), .Latency(4)) u_axi_lite_dram_sim (.*);

  always #4 clk_i = ~clk_i;

  function automatic logic [31:0] next_rand();
    rng ^= rng << 13;
    rng ^= rng >> 17;
    rng ^= rng << 5;
    return rng;
  endfunction

  // Window covers WORDS words starting at BASE
  function automatic logic in_window(input logic [31:0] addr);
    return addr >= BASE && addr < BASE + 8 * WORDS;
  endfunction

  function automatic int word_index(input logic [31:0] addr);
    return (addr - BASE) / 8;
  endfunction

  task automatic report_fail(input string what);
    $display("%s", what);
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  // Scoreboard sampled at the rising edge
  always @(posedge clk_i) begin
    if (arst_n_i) begin
      if ((aw_valid_i && aw_ready_o) != (w_valid_i && w_ready_o)) begin
        report_fail("AW and W were accepted in different cycles");
      end else if (aw_valid_i && aw_ready_o) begin
        if (in_window(aw_addr_i)) begin
          for (int b = 0; b < 8; b++)
            if (w_strb_i[b]) shadow[word_index(aw_addr_i)][8*b +: 8] = w_data_i[8*b +: 8];
          exp_bresp.push_back(2'b00);
        end else begin
          exp_bresp.push_back(2'b11);
        end
      end
      if (ar_valid_i && ar_ready_o) begin
        if (in_window(ar_addr_i)) begin
          exp_data.push_back(shadow[word_index(ar_addr_i)]);
          exp_rresp.push_back(2'b00);
        end else begin
          exp_data.push_back('0);
          exp_rresp.push_back(2'b11);
        end
      end
      if (b_valid_o && b_ready_i) begin
        if (exp_bresp.size() == 0) begin
          report_fail("write response arrived with none expected");
        end else begin
          assert (b_resp_o == exp_bresp[0]) else
            report_fail($sformatf("mismatch b_resp_o: got %h expected %h",
                                  b_resp_o, exp_bresp[0]));
          void'(exp_bresp.pop_front());
        end
      end
      if (r_valid_o && r_ready_i) begin
        if (exp_data.size() == 0) begin
          report_fail("read response arrived with none expected");
        end else begin
          assert (r_data_o == exp_data[0]) else
            report_fail($sformatf("mismatch r_data_o: got %h expected %h",
                                  r_data_o, exp_data[0]));
          assert (r_resp_o == exp_rresp[0]) else
            report_fail($sformatf("mismatch r_resp_o: got %h expected %h",
                                  r_resp_o, exp_rresp[0]));
          void'(exp_data.pop_front());
          void'(exp_rresp.pop_front());
        end
      end
    end
  end

  // Response ready held low or high for random stretches
  always @(negedge clk_i) begin
    if (!stall_on) begin
      r_ready_i = 1'b1;
      b_ready_i = 1'b1;
    end else begin
      if (r_hold == 0) begin
        r_ready_i = next_rand() % 3 == 0;
        r_hold = 1 + next_rand() % 16;
      end
      if (b_hold == 0) begin
        b_ready_i = next_rand() % 3 == 0;
        b_hold = 1 + next_rand() % 16;
      end
      r_hold--;
      b_hold--;
    end
  end

  // Both tasks start and end on a falling edge
  task automatic do_write(input logic [31:0] addr, input logic [63:0] data,
                          input logic [7:0] strb);
    aw_addr_i = addr;
    w_data_i = data;
    w_strb_i = strb;
    aw_valid_i = 1'b1;
    w_valid_i = 1'b1;
    @(posedge clk_i);
    while (!aw_ready_o) @(posedge clk_i);
    @(negedge clk_i);
    aw_valid_i = 1'b0;
    w_valid_i = 1'b0;
  endtask

  task automatic do_read(input logic [31:0] addr);
    ar_addr_i = addr;
    ar_valid_i = 1'b1;
    @(posedge clk_i);
    while (!ar_ready_o) @(posedge clk_i);
    @(negedge clk_i);
    ar_valid_i = 1'b0;
  endtask

  task automatic drain();
    while (exp_data.size() != 0 || exp_bresp.size() != 0) @(negedge clk_i);
  endtask

  initial begin
    #(NUM_OPS * OP_CYCLES * 8 + 1000);
    $display("Run hung, responses stopped arriving");
    $display("=== FAIL ===");
    $fatal(1);
  end

  initial begin
    for (int i = 0; i < WORDS; i++) shadow[i] = '0;
    repeat (2) @(negedge clk_i);
    arst_n_i = 1'b1;
    @(negedge clk_i);
    // Full-strobe writes, then read back
    for (int i = 0; i < 32; i++) do_write(BASE + 8 * i, {next_rand(), next_rand()}, 8'hff);
    for (int i = 0; i < 32; i++) do_read(BASE + 8 * i);
    drain();
    // Byte offsets inside a word
    for (int i = 0; i < 16; i++) do_read(BASE + 8 * (next_rand() % 32) + next_rand() % 8);
    // Partial strobes
    for (int i = 0; i < 16; i++)
      do_write(BASE + 8 * (next_rand() % WORDS), {next_rand(), next_rand()}, 8'(next_rand()));
    for (int i = 0; i < 16; i++) do_read(BASE + 8 * (next_rand() % WORDS));
    drain();
    // Outside the window
    for (int i = 0; i < 8; i++) begin
      do_write(BASE - 8 - 8 * i, {next_rand(), next_rand()}, 8'hff);
      do_write(BASE + 8 * WORDS + 8 * i, {next_rand(), next_rand()}, 8'hff);
      do_read(BASE + 8 * WORDS + 4 * i);
    end
    for (int i = 0; i < WORDS; i++) do_read(BASE + 8 * i);
    drain();
    // Back-pressure with back to back reads
    stall_on = 1'b1;
    for (int i = 0; i < 64; i++) do_read(next_rand() % 5 == 0 ? BASE - 64 : BASE + 8 * (i % WORDS));
    for (int i = 0; i < 16; i++)
      do_write(BASE + 8 * (next_rand() % WORDS), {next_rand(), next_rand()}, 8'h0f);
    drain();
    stall_on = 1'b0;
    // Concurrent read and write streams
    fork
      for (int i = 0; i < 32; i++)
        do_write(BASE + 8 * (next_rand() % WORDS), {next_rand(), next_rand()}, 8'hff);
      for (int i = 0; i < 32; i++) do_read(BASE + 8 * (next_rand() % WORDS));
    join
    drain();
    $display("=== PASS ===");
    $finish;
  end

endmodule : tb_axi_lite_dram_sim

`default_nettype wire

// File: src.f
hw/dram_sim_pkg.sv
hw/dram_req_if.sv
hw/lite_to_dram_req.sv
hw/rw_arbiter.sv
hw/dram_model.sv
hw/axi_lite_dram_sim.sv
verification/axi_lite_dram_sim_props.sv
verification/tb_axi_lite_dram_sim.sv
